// ==== logic/ex_pkg.sv ====
// Shared types for the 12-bit execute unit; opcode values are unique across sets so one enum covers all
package ex_pkg;

    // Data, address and program counter width
    typedef logic [11:0] word_t;

    // Raw immediate field of an instruction
    typedef logic [5:0] imm_t;

    // Z/N/C/V flag register
    typedef logic [3:0] flags_t;

    // Shift amount taken from the operand's low bits
    typedef logic [3:0] shamt_t;

    // Bit position of each flag inside flags_t
    localparam int unsigned flag_z = 3;
    localparam int unsigned flag_n = 2;
    localparam int unsigned flag_c = 1;
    localparam int unsigned flag_v = 0;

    typedef enum logic [1:0] {
        iset_r = 2'd0,
        iset_i = 2'd1,
        iset_s = 2'd2
    } iset_e;

    // R and I sets share the ALU names, li/lis are I set only,
    // the last three codes belong to the S set
    typedef enum logic [3:0] {
        op_mov   = 4'd0,
        op_add   = 4'd1,
        op_sub   = 4'd2,
        op_not   = 4'd3,
        op_and   = 4'd4,
        op_or    = 4'd5,
        op_xor   = 4'd6,
        op_sl    = 4'd7,
        op_sr    = 4'd8,
        op_bcc   = 4'd9,
        op_st    = 4'd10,
        op_li    = 4'd11,
        op_lis   = 4'd12,
        op_srmov = 4'd13,
        op_srbcc = 4'd14,
        op_hlt   = 4'd15
    } opcode_e;

    // Codes 7 to 15 are never taken
    typedef enum logic [3:0] {
        bcc_ra = 4'd0,
        bcc_eq = 4'd1,
        bcc_ne = 4'd2,
        bcc_lt = 4'd3,
        bcc_gt = 4'd4,
        bcc_le = 4'd5,
        bcc_ge = 4'd6
    } bcc_e;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_ack     = 2'd1,
        st_halted  = 2'd2
    } ctrl_state_e;

endpackage

// ==== logic/ex_control.sv ====
// Four-phase req/ack slave; req must stay high until ack rises, only reset leaves the halted state
`timescale 1ns/10ps

module ex_control (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    input  ex_pkg::opcode_e    opcode,
    input  ex_pkg::iset_e      iset,
    output logic               ack,
    output logic               halted,
    output logic               load
);

    ex_pkg::ctrl_state_e state;
    ex_pkg::ctrl_state_e state_next;

    // Set when the accepted instruction is a halt
    logic halt_pend;
    logic is_hlt;

    assign is_hlt = (iset == ex_pkg::iset_s) && (opcode == ex_pkg::op_hlt);

    // Datapath captures in the same cycle the request is accepted
    assign load = (state == ex_pkg::st_idle) && req;

    assign ack    = (state == ex_pkg::st_ack);
    assign halted = (state == ex_pkg::st_halted);

    always_comb begin
        state_next = state;
        case (state)
            ex_pkg::st_idle: begin
                if (req) begin
                    state_next = ex_pkg::st_ack;
                end
            end
            ex_pkg::st_ack: begin
                // Wait for the requester to drop req before closing
                if (!req) begin
                    if (halt_pend) begin
                        state_next = ex_pkg::st_halted;
                    end else begin
                        state_next = ex_pkg::st_idle;
                    end
                end
            end
            ex_pkg::st_halted: begin
                state_next = ex_pkg::st_halted;
            end
            default: begin
                state_next = ex_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ex_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            halt_pend <= 1'b0;
        end else if (load) begin
            halt_pend <= is_hlt;
        end
    end

    // No new request is accepted while the current one is still acknowledged
    a_no_load_in_ack: assert property (
        @(posedge clk) disable iff (rst)
        !(load && ack)
    ) else $error("load high while ack is high");

    // Once halted the unit never acknowledges again
    a_halt_no_ack: assert property (
        @(posedge clk) disable iff (rst)
        halted |=> !ack
    ) else $error("ack raised after halt");

endmodule

// ==== logic/operand_select.sv ====
// Immediate register updates only on I-set li/lis; operand always sees the value before this update
`timescale 1ns/10ps

module operand_select (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  ex_pkg::iset_e      iset,
    input  ex_pkg::opcode_e    opcode,
    input  ex_pkg::imm_t       imm_val,
    input  logic               imm_hilo,
    input  logic               imm_en,
    input  ex_pkg::word_t      src_data,
    output ex_pkg::word_t      operand,
    output ex_pkg::word_t      imm_reg
);

    ex_pkg::word_t imm_next;
    logic          is_li;
    logic          is_lis;

    assign is_li  = (iset == ex_pkg::iset_i) && (opcode == ex_pkg::op_li);
    assign is_lis = (iset == ex_pkg::iset_i) && (opcode == ex_pkg::op_lis);

    always_comb begin
        imm_next = imm_reg;
        if (is_li) begin
            // Half load keeps the other half untouched
            if (imm_hilo) begin
                imm_next = {imm_val, imm_reg[5:0]};
            end else begin
                imm_next = {imm_reg[11:6], imm_val};
            end
        end else if (is_lis) begin
            imm_next = {{6{imm_val[5]}}, imm_val};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            imm_reg <= '0;
        end else if (load) begin
            imm_reg <= imm_next;
        end
    end

    // Source operand for the ALU
    assign operand = imm_en ? imm_reg : src_data;

endmodule

// ==== logic/exec_alu.sv ====
// ALU for the R and I sets; S-set and branch instructions give a zero result and keep the flags
`timescale 1ns/10ps

module exec_alu (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  ex_pkg::iset_e      iset,
    input  ex_pkg::opcode_e    opcode,
    input  logic               sgn_en,
    input  ex_pkg::word_t      operand,
    input  ex_pkg::word_t      tgt_data,
    input  ex_pkg::word_t      src_data,
    input  ex_pkg::word_t      imm_reg,
    output ex_pkg::word_t      result,
    output ex_pkg::word_t      store_data,
    output ex_pkg::flags_t     flags
);

    ex_pkg::word_t  res_d;
    ex_pkg::word_t  store_d;
    ex_pkg::flags_t flags_d;
    ex_pkg::shamt_t shamt;
    logic [12:0]    sum;
    logic           carry;
    logic           ovf;
    logic           flag_wr;
    logic           alu_set;

    assign alu_set = (iset == ex_pkg::iset_r) || (iset == ex_pkg::iset_i);
    assign shamt   = operand[3:0];

    always_comb begin
        res_d   = '0;
        store_d = '0;
        sum     = '0;
        carry   = 1'b0;
        ovf     = 1'b0;
        flag_wr = 1'b0;
        if (alu_set) begin
            case (opcode)
                ex_pkg::op_mov: begin
                    res_d   = operand;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_add: begin
                    sum     = {1'b0, tgt_data} + {1'b0, operand};
                    res_d   = sum[11:0];
                    carry   = sum[12];
                    ovf     = (tgt_data[11] == operand[11]) && (res_d[11] != tgt_data[11]);
                    flag_wr = 1'b1;
                end
                ex_pkg::op_sub: begin
                    // Two's complement add where carry set means no borrow
                    sum     = {1'b0, tgt_data} + {1'b0, ~operand} + 13'd1;
                    res_d   = sum[11:0];
                    carry   = sum[12];
                    ovf     = (tgt_data[11] != operand[11]) && (res_d[11] != tgt_data[11]);
                    flag_wr = 1'b1;
                end
                ex_pkg::op_not: begin
                    res_d   = ~tgt_data;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_and: begin
                    res_d   = tgt_data & operand;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_or: begin
                    res_d   = tgt_data | operand;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_xor: begin
                    res_d   = tgt_data ^ operand;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_sl: begin
                    res_d   = tgt_data << shamt;
                    flag_wr = 1'b1;
                end
                ex_pkg::op_sr: begin
                    if (sgn_en) begin
                        res_d = ex_pkg::word_t'($signed(tgt_data) >>> shamt);
                    end else begin
                        res_d = tgt_data >> shamt;
                    end
                    flag_wr = 1'b1;
                end
                ex_pkg::op_st: begin
                    // Address comes from the target register
                    res_d   = tgt_data;
                    store_d = (iset == ex_pkg::iset_i) ? imm_reg : src_data;
                end
                default: begin
                    res_d = '0;
                end
            endcase
        end
    end

    always_comb begin
        flags_d                 = '0;
        flags_d[ex_pkg::flag_z] = (res_d == '0);
        flags_d[ex_pkg::flag_n] = res_d[11];
        flags_d[ex_pkg::flag_c] = carry;
        flags_d[ex_pkg::flag_v] = ovf;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result     <= '0;
            store_data <= '0;
            flags      <= '0;
        end else if (load) begin
            result     <= res_d;
            store_data <= store_d;
            if (flag_wr) begin
                flags <= flags_d;
            end
        end
    end

    // Flags only move on a transaction accepted by the control FSM
    a_flags_hold: assert property (
        @(posedge clk) disable iff (rst)
        !load |=> $stable(flags)
    ) else $error("flags changed without load");

endmodule

// ==== logic/branch_unit.sv ====
// Conditions use the flag register from before the instruction; unknown condition codes are not taken
`timescale 1ns/10ps

module branch_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  ex_pkg::iset_e      iset,
    input  ex_pkg::opcode_e    opcode,
    input  ex_pkg::bcc_e       bcc,
    input  ex_pkg::flags_t     flags,
    input  ex_pkg::word_t      pc,
    input  ex_pkg::word_t      lr,
    input  ex_pkg::word_t      tgt_data,
    input  ex_pkg::word_t      imm_reg,
    input  ex_pkg::imm_t       imm_val,
    output logic               branch_taken,
    output ex_pkg::word_t      next_pc
);

    logic          cond;
    logic          lt;
    logic          taken_d;
    ex_pkg::word_t next_pc_d;

    assign lt = flags[ex_pkg::flag_n] ^ flags[ex_pkg::flag_v];

    always_comb begin
        case (bcc)
            ex_pkg::bcc_ra: cond = 1'b1;
            ex_pkg::bcc_eq: cond = flags[ex_pkg::flag_z];
            ex_pkg::bcc_ne: cond = !flags[ex_pkg::flag_z];
            ex_pkg::bcc_lt: cond = lt;
            ex_pkg::bcc_gt: cond = !flags[ex_pkg::flag_z] && !lt;
            ex_pkg::bcc_le: cond = flags[ex_pkg::flag_z] || lt;
            ex_pkg::bcc_ge: cond = !lt;
            default:        cond = 1'b0;
        endcase
    end

    always_comb begin
        taken_d   = 1'b0;
        next_pc_d = pc;
        if (iset == ex_pkg::iset_r && opcode == ex_pkg::op_bcc) begin
            // Absolute jump through the target register
            taken_d = cond;
            if (cond) begin
                next_pc_d = tgt_data;
            end
        end else if (iset == ex_pkg::iset_i && opcode == ex_pkg::op_bcc) begin
            taken_d = cond;
            if (cond) begin
                next_pc_d = pc + {{6{imm_reg[5]}}, imm_reg[5:0]};
            end
        end else if (iset == ex_pkg::iset_s && opcode == ex_pkg::op_srbcc) begin
            // Return style branch relative to the link register
            taken_d = cond;
            if (cond) begin
                next_pc_d = lr + {{6{imm_val[5]}}, imm_val};
            end
        end
        // srmov falls through with next_pc = pc for the link save
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            branch_taken <= 1'b0;
            next_pc      <= '0;
        end else if (load) begin
            branch_taken <= taken_d;
            next_pc      <= next_pc_d;
        end
    end

endmodule

// ==== logic/exec_unit.sv ====
// Execute unit top; outputs are valid while ack is high and hold until the next accepted request
`timescale 1ns/10ps

module exec_unit (
    input  logic               clk,
    input  logic               rst,
    input  logic               req,
    output logic               ack,
    output logic               halted,
    input  ex_pkg::iset_e      iset,
    input  ex_pkg::opcode_e    opcode,
    input  ex_pkg::bcc_e       bcc,
    input  ex_pkg::imm_t       imm_val,
    input  logic               imm_hilo,
    input  logic               imm_en,
    input  logic               sgn_en,
    input  ex_pkg::word_t      pc,
    input  ex_pkg::word_t      lr,
    input  ex_pkg::word_t      src_data,
    input  ex_pkg::word_t      tgt_data,
    output ex_pkg::word_t      result,
    output ex_pkg::flags_t     flags,
    output ex_pkg::word_t      store_data,
    output logic               branch_taken,
    output ex_pkg::word_t      next_pc
);

    logic          load;
    ex_pkg::word_t operand;
    ex_pkg::word_t imm_reg;

    ex_control control_i (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .opcode  (opcode),
        .iset    (iset),
        .ack     (ack),
        .halted  (halted),
        .load    (load)
    );

    operand_select operands_i (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .iset     (iset),
        .opcode   (opcode),
        .imm_val  (imm_val),
        .imm_hilo (imm_hilo),
        .imm_en   (imm_en),
        .src_data (src_data),
        .operand  (operand),
        .imm_reg  (imm_reg)
    );

    exec_alu alu_i (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .iset       (iset),
        .opcode     (opcode),
        .sgn_en     (sgn_en),
        .operand    (operand),
        .tgt_data   (tgt_data),
        .src_data   (src_data),
        .imm_reg    (imm_reg),
        .result     (result),
        .store_data (store_data),
        .flags      (flags)
    );

    // Flags feed back unregistered, so branches see the pre-instruction value
    branch_unit branch_i (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .iset         (iset),
        .opcode       (opcode),
        .bcc          (bcc),
        .flags        (flags),
        .pc           (pc),
        .lr           (lr),
        .tgt_data     (tgt_data),
        .imm_reg      (imm_reg),
        .imm_val      (imm_val),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

endmodule

// ==== dv/exec_unit_tb.sv ====
// Directed testbench for exec_unit; stops at the first mismatch, operands come from a fixed seed
`timescale 1ns/10ps

module exec_unit_tb;

    // About 140 transactions of two cycles each plus the halt wait, with wide margin
    localparam int unsigned max_cycles = 2000;

    logic               clk = 1'b0;
    logic               rst;
    logic               req;
    logic               ack;
    logic               halted;
    ex_pkg::iset_e      iset;
    ex_pkg::opcode_e    opcode;
    ex_pkg::bcc_e       bcc;
    ex_pkg::imm_t       imm_val;
    logic               imm_hilo;
    logic               imm_en;
    logic               sgn_en;
    ex_pkg::word_t      pc;
    ex_pkg::word_t      lr;
    ex_pkg::word_t      src_data;
    ex_pkg::word_t      tgt_data;
    ex_pkg::word_t      result;
    ex_pkg::flags_t     flags;
    ex_pkg::word_t      store_data;
    logic               branch_taken;
    ex_pkg::word_t      next_pc;

    // Reference model state
    ex_pkg::flags_t     ref_flags;
    ex_pkg::word_t      ref_imm;

    // Outputs sampled while ack is high
    ex_pkg::word_t      got_result;
    ex_pkg::word_t      got_store;
    ex_pkg::word_t      got_next_pc;
    ex_pkg::flags_t     got_flags;
    logic               got_taken;

    int unsigned        cycles;
    int unsigned        ack_rises;

    exec_unit dut_i (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .ack          (ack),
        .halted       (halted),
        .iset         (iset),
        .opcode       (opcode),
        .bcc          (bcc),
        .imm_val      (imm_val),
        .imm_hilo     (imm_hilo),
        .imm_en       (imm_en),
        .sgn_en       (sgn_en),
        .pc           (pc),
        .lr           (lr),
        .src_data     (src_data),
        .tgt_data     (tgt_data),
        .result       (result),
        .flags        (flags),
        .store_data   (store_data),
        .branch_taken (branch_taken),
        .next_pc      (next_pc)
    );

    always #10 clk = ~clk;

    always @(posedge ack) begin
        ack_rises++;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_val(input string name, input int unsigned exp, input int unsigned act);
        assert (exp == act) else begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Check failed: %s", what);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic ex_pkg::word_t sext6(input ex_pkg::imm_t v);
        return {{6{v[5]}}, v};
    endfunction

    function automatic ex_pkg::flags_t make_flags(input ex_pkg::word_t res, input logic c,
                                                  input logic v);
        ex_pkg::flags_t f;
        f                 = '0;
        f[ex_pkg::flag_z] = (res == 12'h000);
        f[ex_pkg::flag_n] = res[11];
        f[ex_pkg::flag_c] = c;
        f[ex_pkg::flag_v] = v;
        return f;
    endfunction

    // Branch conditions by their definitions on Z, N and V
    function automatic bit cond_holds(input logic [3:0] code, input ex_pkg::flags_t f);
        bit z;
        bit lt;
        z  = f[ex_pkg::flag_z];
        lt = f[ex_pkg::flag_n] ^ f[ex_pkg::flag_v];
        case (code)
            ex_pkg::bcc_ra: return 1'b1;
            ex_pkg::bcc_eq: return z;
            ex_pkg::bcc_ne: return !z;
            ex_pkg::bcc_lt: return lt;
            ex_pkg::bcc_gt: return !z && !lt;
            ex_pkg::bcc_le: return z || lt;
            ex_pkg::bcc_ge: return !lt;
            default:        return 1'b0;
        endcase
    endfunction

    // Integer arithmetic model of the ALU operations
    task automatic model_alu(input ex_pkg::opcode_e op, input ex_pkg::word_t t,
                             input ex_pkg::word_t o, input logic sgn,
                             output ex_pkg::word_t res, output logic c, output logic v);
        int a;
        int b;
        int sa;
        int sb;
        int s;
        a  = t;
        b  = o;
        sa = int'($signed(t));
        sb = int'($signed(o));
        c  = 1'b0;
        v  = 1'b0;
        case (op)
            ex_pkg::op_mov: res = o;
            ex_pkg::op_add: begin
                s   = a + b;
                res = s[11:0];
                c   = (s > 4095);
                v   = (sa + sb > 2047) || (sa + sb < -2048);
            end
            ex_pkg::op_sub: begin
                s   = a - b;
                res = s[11:0];
                c   = (a >= b);
                v   = (sa - sb > 2047) || (sa - sb < -2048);
            end
            ex_pkg::op_not: res = ~t;
            ex_pkg::op_and: res = t & o;
            ex_pkg::op_or:  res = t | o;
            ex_pkg::op_xor: res = t ^ o;
            ex_pkg::op_sl:  res = ex_pkg::word_t'(a << o[3:0]);
            ex_pkg::op_sr:  res = sgn ? ex_pkg::word_t'(sa >>> o[3:0])
                                      : ex_pkg::word_t'(a >> o[3:0]);
            default:        res = '0;
        endcase
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst       = 1'b0;
        ref_flags = '0;
        ref_imm   = '0;
    endtask

    // Four-phase handshake started on a falling edge with the instruction already driven
    task automatic issue(input string name);
        int unsigned rises_before;
        rises_before = ack_rises;
        check_true(!ack, {name, ": ack high before the request"});
        req = 1'b1;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        got_result  = result;
        got_store   = store_data;
        got_next_pc = next_pc;
        got_flags   = flags;
        got_taken   = branch_taken;
        req = 1'b0;
        @(negedge clk);
        check_true(!ack, {name, ": ack did not fall after req fell"});
        check_val({name, " ack rises"}, rises_before + 1, ack_rises);
    endtask

    task automatic run_alu(input string name, input ex_pkg::iset_e set, input ex_pkg::opcode_e op,
                           input ex_pkg::word_t t, input ex_pkg::word_t o, input logic use_imm,
                           input logic sgn);
        ex_pkg::word_t opnd;
        ex_pkg::word_t exp_res;
        logic          c;
        logic          v;
        iset     = set;
        opcode   = op;
        imm_en   = use_imm;
        sgn_en   = sgn;
        tgt_data = t;
        src_data = o;
        opnd     = use_imm ? ref_imm : o;
        issue(name);
        model_alu(op, t, opnd, sgn, exp_res, c, v);
        ref_flags = make_flags(exp_res, c, v);
        check_val(name, exp_res, got_result);
        check_val({name, " flags"}, ref_flags, got_flags);
    endtask

    task automatic run_store(input string name, input ex_pkg::iset_e set, input ex_pkg::word_t t,
                             input ex_pkg::word_t s);
        iset     = set;
        opcode   = ex_pkg::op_st;
        imm_en   = 1'b0;
        tgt_data = t;
        src_data = s;
        issue(name);
        check_val({name, " address"}, t, got_result);
        check_val({name, " data"}, (set == ex_pkg::iset_i) ? ref_imm : s, got_store);
        check_val({name, " flags"}, ref_flags, got_flags);
    endtask

    task automatic load_imm(input string name, input ex_pkg::opcode_e op, input logic hilo,
                            input ex_pkg::imm_t val);
        iset     = ex_pkg::iset_i;
        opcode   = op;
        imm_hilo = hilo;
        imm_val  = val;
        issue(name);
        if (op == ex_pkg::op_lis) begin
            ref_imm = sext6(val);
        end else if (hilo) begin
            ref_imm = {val, ref_imm[5:0]};
        end else begin
            ref_imm = {ref_imm[11:6], val};
        end
        check_val({name, " result"}, 0, got_result);
        check_val({name, " flags"}, ref_flags, got_flags);
    endtask

    task automatic run_branch(input string name, input ex_pkg::iset_e set,
                              input ex_pkg::opcode_e op, input logic [3:0] code);
        ex_pkg::word_t pc_v;
        ex_pkg::word_t lr_v;
        ex_pkg::word_t tgt_v;
        ex_pkg::imm_t  imm_v;
        ex_pkg::word_t exp_pc;
        bit            taken;
        pc_v  = ex_pkg::word_t'($urandom);
        lr_v  = ex_pkg::word_t'($urandom);
        tgt_v = ex_pkg::word_t'($urandom);
        imm_v = ex_pkg::imm_t'($urandom);
        iset     = set;
        opcode   = op;
        bcc      = ex_pkg::bcc_e'(code);
        pc       = pc_v;
        lr       = lr_v;
        tgt_data = tgt_v;
        imm_val  = imm_v;
        issue(name);
        taken  = (op != ex_pkg::op_srmov) && cond_holds(code, ref_flags);
        exp_pc = pc_v;
        if (taken) begin
            case (set)
                ex_pkg::iset_r: exp_pc = tgt_v;
                ex_pkg::iset_i: exp_pc = pc_v + sext6(ref_imm[5:0]);
                default:        exp_pc = lr_v + sext6(imm_v);
            endcase
        end
        check_val({name, " taken"}, taken, got_taken);
        check_val({name, " next_pc"}, exp_pc, got_next_pc);
        check_val({name, " result"}, 0, got_result);
        check_val({name, " flags"}, ref_flags, got_flags);
    endtask

    task automatic test_reset();
        check_val("reset ack", 0, ack);
        check_val("reset halted", 0, halted);
        check_val("reset branch_taken", 0, branch_taken);
        check_val("reset flags", 0, flags);
        check_true(dut_i.control_i.state == ex_pkg::st_idle, "control FSM not idle after reset");
    endtask

    task automatic test_add_sub();
        ex_pkg::word_t t;
        ex_pkg::word_t o;
        run_alu("add carry zero", ex_pkg::iset_r, ex_pkg::op_add, 12'h800, 12'h800, 1'b0, 1'b0);
        run_alu("add overflow", ex_pkg::iset_r, ex_pkg::op_add, 12'h7ff, 12'h001, 1'b0, 1'b0);
        run_alu("sub zero", ex_pkg::iset_r, ex_pkg::op_sub, 12'h123, 12'h123, 1'b0, 1'b0);
        run_alu("sub borrow", ex_pkg::iset_r, ex_pkg::op_sub, 12'h003, 12'h005, 1'b0, 1'b0);
        run_alu("sub overflow", ex_pkg::iset_r, ex_pkg::op_sub, 12'h800, 12'h001, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            t = ex_pkg::word_t'($urandom);
            o = ex_pkg::word_t'($urandom);
            run_alu("add random", ex_pkg::iset_r, ex_pkg::op_add, t, o, 1'b0, 1'b0);
            run_alu("sub random", ex_pkg::iset_r, ex_pkg::op_sub, o, t, 1'b0, 1'b0);
        end
    endtask

    task automatic test_logic_shift();
        ex_pkg::word_t t;
        ex_pkg::word_t o;
        t = ex_pkg::word_t'($urandom) | 12'h800;
        o = ex_pkg::word_t'($urandom);
        run_alu("mov", ex_pkg::iset_r, ex_pkg::op_mov, t, o, 1'b0, 1'b0);
        run_alu("not", ex_pkg::iset_r, ex_pkg::op_not, t, o, 1'b0, 1'b0);
        run_alu("and", ex_pkg::iset_r, ex_pkg::op_and, t, o, 1'b0, 1'b0);
        run_alu("or", ex_pkg::iset_r, ex_pkg::op_or, t, o, 1'b0, 1'b0);
        run_alu("xor", ex_pkg::iset_r, ex_pkg::op_xor, t, o, 1'b0, 1'b0);
        run_alu("sl", ex_pkg::iset_r, ex_pkg::op_sl, t, 12'h003, 1'b0, 1'b0);
        run_alu("sr logical", ex_pkg::iset_r, ex_pkg::op_sr, t, 12'h005, 1'b0, 1'b0);
        run_alu("sr arithmetic", ex_pkg::iset_r, ex_pkg::op_sr, t, 12'h005, 1'b0, 1'b1);
        run_store("r st", ex_pkg::iset_r, o, t);
        run_branch("r bcc keeps flags", ex_pkg::iset_r, ex_pkg::op_bcc, ex_pkg::bcc_ra);
    endtask

    task automatic test_immediate();
        load_imm("li high", ex_pkg::op_li, 1'b1, 6'h2a);
        load_imm("li low", ex_pkg::op_li, 1'b0, 6'h15);
        run_alu("imm add", ex_pkg::iset_i, ex_pkg::op_add, 12'h0f3, 12'h555, 1'b1, 1'b0);
        load_imm("lis negative", ex_pkg::op_lis, 1'b0, 6'h30);
        run_alu("imm mov", ex_pkg::iset_i, ex_pkg::op_mov, 12'h000, 12'h321, 1'b1, 1'b0);
        run_store("i st", ex_pkg::iset_i, 12'h0a0, 12'h777);
    endtask

    task automatic test_branches();
        ex_pkg::word_t set_t[4];
        ex_pkg::word_t set_o[4];
        // Flags Z, N, positive, V only
        set_t = '{12'h123, 12'h003, 12'h005, 12'h800};
        set_o = '{12'h123, 12'h005, 12'h003, 12'h001};
        for (int k = 0; k < 4; k++) begin
            run_alu("flag setup", ex_pkg::iset_r, ex_pkg::op_sub, set_t[k], set_o[k], 1'b0, 1'b0);
            for (int code = 0; code < 8; code++) begin
                run_branch("r bcc", ex_pkg::iset_r, ex_pkg::op_bcc, code[3:0]);
                run_branch("i bcc", ex_pkg::iset_i, ex_pkg::op_bcc, code[3:0]);
                run_branch("s srbcc", ex_pkg::iset_s, ex_pkg::op_srbcc, code[3:0]);
            end
        end
        run_branch("srmov", ex_pkg::iset_s, ex_pkg::op_srmov, ex_pkg::bcc_ra);
    endtask

    task automatic test_halt();
        int unsigned rises_before;
        iset   = ex_pkg::iset_s;
        opcode = ex_pkg::op_hlt;
        issue("halt");
        check_val("halted after halt", 1, halted);
        rises_before = ack_rises;
        req = 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_val("ack while halted", 0, ack);
        end
        req = 1'b0;
        check_val("ack rises while halted", rises_before, ack_rises);
        apply_reset();
        check_val("halted after reset", 0, halted);
        check_true(dut_i.control_i.state == ex_pkg::st_idle, "control FSM not idle after reset");
        run_alu("add after reset", ex_pkg::iset_r, ex_pkg::op_add, 12'h010, 12'h020, 1'b0, 1'b0);
    endtask

    initial begin
        void'($urandom(32'h6853));
        cycles    = 0;
        ack_rises = 0;
        rst       = 1'b1;
        req       = 1'b0;
        iset      = ex_pkg::iset_r;
        opcode    = ex_pkg::op_mov;
        bcc       = ex_pkg::bcc_ra;
        imm_val   = '0;
        imm_hilo  = 1'b0;
        imm_en    = 1'b0;
        sgn_en    = 1'b0;
        pc        = '0;
        lr        = '0;
        src_data  = '0;
        tgt_data  = '0;
        apply_reset();
        test_reset();
        test_add_sub();
        test_logic_shift();
        test_immediate();
        test_branches();
        test_halt();
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/ex_pkg.sv
logic/ex_control.sv
logic/operand_select.sv
logic/exec_alu.sv
logic/branch_unit.sv
logic/exec_unit.sv
dv/exec_unit_tb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

sources:
  - files:
      - logic/ex_pkg.sv
      - logic/ex_control.sv
      - logic/operand_select.sv
      - logic/exec_alu.sv
      - logic/branch_unit.sv
      - logic/exec_unit.sv
  - target: test
    files:
      - dv/exec_unit_tb.sv
